//--- Makefile
TOP := mhp_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f logic/*.sv logic/*.svh tb/*.sv
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps \
		--top-module mhp_top -f verilog.f

clean:
	rm -rf obj_dir

//--- logic/frame_ram.sv
`timescale 1ns/10ps
`include "mhp_defines.svh"

module frame_ram (
  input  logic             i_clk,
  input  mhp_pkg::ram_wr_t i_wr_a,
  input  mhp_pkg::ram_wr_t i_wr_b,
  input  mhp_pkg::addr_t   i_rd_addr,
  output mhp_pkg::byte_t   o_rd_data
);

  logic [7:0] mem [0:`FRAME_MAX-1];

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  // receiver on a, engine on b
  // the handshake keeps them apart, a wins anyway
  always_ff @(posedge i_clk) begin
    if (i_wr_a.en) begin
      mem[i_wr_a.addr] <= i_wr_a.data;
    end else if (i_wr_b.en) begin
      mem[i_wr_b.addr] <= i_wr_b.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  // data one cycle after the address, old value on a collision
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

//--- logic/frame_rx.sv
`timescale 1ns/10ps
`include "mhp_defines.svh"

module frame_rx (
  input  logic             i_clk,
  input  logic             i_rst,
  input  mhp_pkg::byte_t   i_rx_data,
  input  logic             i_rx_ready,
  output logic             o_rx_req,
  output mhp_pkg::ram_wr_t o_wr,
  output logic             o_frame_req,
  output mhp_pkg::byte_t   o_frame_len,
  input  logic             i_frame_ack
);
  import mhp_pkg::*;

  rx_state_e                         state;
  logic                              rx_req;
  logic                              wr_en;
  byte_t                             wr_data;
  byte_t                             frame_len;
  logic [$clog2(`RX_GAP_LIMIT)-1:0]  gap_cnt;
  logic                              frame_req;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= RX_IDLE;
      rx_req    <= 1'b0;
      wr_en     <= 1'b0;
      frame_len <= '0;
      gap_cnt   <= '0;
      frame_req <= 1'b0;
    end else begin
      rx_req <= 1'b0;
      wr_en  <= 1'b0;
      case (state)
        // first byte of a new frame
        RX_IDLE: begin
          if (i_rx_ready) begin
            rx_req <= 1'b1;
            state  <= RX_POP;
          end
        end
        // pop cycle, byte shows up next
        RX_POP: state <= RX_LATCH;
        RX_LATCH: begin
          // bytes past the ram end are dropped
          wr_en <= (frame_len < `FRAME_MAX);
          state <= RX_STORE;
        end
        RX_STORE: begin
          if (frame_len < `FRAME_MAX) begin
            frame_len <= frame_len + 8'd1;
          end
          gap_cnt <= '0;
          state   <= RX_POLL;
        end
        RX_POLL: begin
          if (i_rx_ready) begin
            rx_req <= 1'b1;
            state  <= RX_POP;
          end else if (gap_cnt == ($bits(gap_cnt))'(`RX_GAP_LIMIT - 1)) begin
            frame_req <= 1'b1;
            state     <= RX_HOLD;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        // frame owned by the engine, fifo backs up
        RX_HOLD: begin
          if (i_frame_ack) begin
            frame_req <= 1'b0;
            state     <= RX_RELEASE;
          end
        end
        RX_RELEASE: begin
          if (!i_frame_ack) begin
            frame_len <= '0;
            state     <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == RX_LATCH) begin
      wr_data <= i_rx_data;
    end
  end

  // address is the running length, bumped after the write
  assign o_wr        = '{en: wr_en, addr: frame_len[`RAM_AW-1:0], data: wr_data};
  assign o_rx_req    = rx_req;
  assign o_frame_req = frame_req;
  assign o_frame_len = frame_len;

endmodule

//--- logic/mhp_defines.svh
`ifndef MHP_DEFINES_SVH
`define MHP_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// frame storage
////////////////////////////////////////////////////////////////////////////

// ram depth, also the longest frame kept
`define FRAME_MAX     64
`define RAM_AW        6

// src(2) dst(2) size(2) type(1)
`define HDR_LEN       7

// idle cycles with an empty fifo that close a frame
`define RX_GAP_LIMIT  63

////////////////////////////////////////////////////////////////////////////
// reply layout
////////////////////////////////////////////////////////////////////////////

// bytes per reply, zero padded
`define REPLY_LEN     50

// checksum high byte, low byte right after
`define CSUM_POS      9

// opcodes in type[6:0], type[7] is direction
`define OP_PING       7'h01
`define OP_ADDR       7'h04
`define ACK_BIT       4

`endif

//--- logic/mhp_pkg.sv
`include "mhp_defines.svh"

package mhp_pkg;

  typedef logic [7:0]         byte_t;
  typedef logic [`RAM_AW-1:0] addr_t;

  // one ram write per cycle
  typedef struct packed {
    logic  en;
    addr_t addr;
    byte_t data;
  } ram_wr_t;

  // output byte, valid only with ready
  typedef struct packed {
    logic  valid;
    byte_t data;
  } tx_beat_t;

  // header in wire order, src first
  typedef struct packed {
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] size;
    byte_t       dtype;
  } frame_hdr_t;

  typedef enum logic [1:0] {CMD_PING, CMD_ADDR, CMD_NONE} cmd_op_e;

  typedef enum logic [2:0] {
    RX_IDLE, RX_POP, RX_LATCH, RX_STORE, RX_POLL, RX_HOLD, RX_RELEASE
  } rx_state_e;

  typedef enum logic [3:0] {
    ENG_IDLE, ENG_HDR_RD, ENG_HDR_LD, ENG_DECODE, ENG_FILL, ENG_SUM_RD,
    ENG_SUM_LD, ENG_CSUM_HI, ENG_CSUM_LO, ENG_SEND, ENG_WAIT_TX, ENG_ACK
  } eng_state_e;

  typedef enum logic [1:0] {TX_IDLE, TX_FETCH, TX_LOAD, TX_SEND} tx_state_e;

endpackage

//--- logic/mhp_top.sv
`timescale 1ns/10ps

module mhp_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  mhp_pkg::byte_t    i_rx_data,
  input  logic              i_rx_ready,
  output logic              o_rx_req,
  output mhp_pkg::tx_beat_t o_tx,
  input  logic              i_tx_ready
);
  import mhp_pkg::*;

  // receiver to engine handshake
  logic    frame_req;
  logic    frame_ack;
  byte_t   frame_len;

  // ram ports
  ram_wr_t rx_wr;
  ram_wr_t eng_wr;
  addr_t   rd_addr;
  byte_t   rd_data;

  frame_rx u_frame_rx (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rx_data   (i_rx_data),
    .i_rx_ready  (i_rx_ready),
    .o_rx_req    (o_rx_req),
    .o_wr        (rx_wr),
    .o_frame_req (frame_req),
    .o_frame_len (frame_len),
    .i_frame_ack (frame_ack)
  );

  frame_ram u_frame_ram (
    .i_clk     (i_clk),
    .i_wr_a    (rx_wr),
    .i_wr_b    (eng_wr),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  reply_engine u_reply_engine (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_frame_req (frame_req),
    .i_frame_len (frame_len),
    .o_frame_ack (frame_ack),
    .o_wr        (eng_wr),
    .o_rd_addr   (rd_addr),
    .i_rd_data   (rd_data),
    .o_tx        (o_tx),
    .i_tx_ready  (i_tx_ready)
  );

endmodule

//--- logic/reply_engine.sv
`timescale 1ns/10ps
`include "mhp_defines.svh"

module reply_engine (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_frame_req,
  input  mhp_pkg::byte_t    i_frame_len,
  output logic              o_frame_ack,
  output mhp_pkg::ram_wr_t  o_wr,
  output mhp_pkg::addr_t    o_rd_addr,
  input  mhp_pkg::byte_t    i_rd_data,
  output mhp_pkg::tx_beat_t o_tx,
  input  logic              i_tx_ready
);
  import mhp_pkg::*;

  eng_state_e  state;
  cmd_op_e     cmd;
  cmd_op_e     cmd_dec;
  frame_hdr_t  hdr;
  addr_t       idx;
  logic [15:0] csum;
  logic        wr_en;
  addr_t       wr_addr;
  byte_t       wr_data;
  logic        frame_ack;
  logic        tx_start;
  logic        tx_done;
  addr_t       tx_rd_addr;

  // reply bytes 0..8, addresses swapped
  function automatic byte_t tmpl_byte(input addr_t pos, input cmd_op_e op,
                                      input frame_hdr_t h);
    logic grant;
    grant = (op == CMD_ADDR);
    case (pos)
      6'd0:    return h.dst[15:8];
      6'd1:    return h.dst[7:0];
      6'd2:    return h.src[15:8];
      6'd3:    return h.src[7:0];
      6'd5:    return grant ? 8'h02 : 8'h01;
      6'd6:    return grant ? 8'h92 : 8'h81;
      6'd7:    return grant ? 8'h01 : 8'h00;
      6'd8:    return grant ? 8'h20 : 8'h00;
      default: return 8'h00;
    endcase
  endfunction

  // ack flag wins over the opcode
  always_comb begin
    if (hdr.dtype[`ACK_BIT]) begin
      cmd_dec = CMD_NONE;
    end else if (hdr.dtype[6:0] == `OP_PING) begin
      cmd_dec = CMD_PING;
    end else if (hdr.dtype[6:0] == `OP_ADDR) begin
      cmd_dec = CMD_ADDR;
    end else begin
      cmd_dec = CMD_NONE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ENG_IDLE;
      cmd       <= CMD_NONE;
      idx       <= '0;
      wr_en     <= 1'b0;
      frame_ack <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      case (state)
        ENG_IDLE: begin
          if (i_frame_req) begin
            idx <= '0;
            // runt frames are never answered
            if (i_frame_len < 8'(`HDR_LEN)) begin
              cmd   <= CMD_NONE;
              state <= ENG_ACK;
            end else begin
              state <= ENG_HDR_RD;
            end
          end
        end
        ENG_HDR_RD: state <= ENG_HDR_LD;
        ENG_HDR_LD: begin
          if (idx == addr_t'(`HDR_LEN - 1)) begin
            state <= ENG_DECODE;
          end else begin
            idx   <= idx + 1'b1;
            state <= ENG_HDR_RD;
          end
        end
        ENG_DECODE: begin
          cmd   <= cmd_dec;
          idx   <= '0;
          state <= (cmd_dec == CMD_NONE) ? ENG_ACK : ENG_FILL;
        end
        // one template byte per cycle
        ENG_FILL: begin
          wr_en <= 1'b1;
          if (idx == addr_t'(`CSUM_POS - 1)) begin
            idx   <= '0;
            state <= ENG_SUM_RD;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        // sum read back from ram
        ENG_SUM_RD: state <= ENG_SUM_LD;
        ENG_SUM_LD: begin
          if (idx == addr_t'(`CSUM_POS - 1)) begin
            state <= ENG_CSUM_HI;
          end else begin
            idx   <= idx + 1'b1;
            state <= ENG_SUM_RD;
          end
        end
        ENG_CSUM_HI: begin
          wr_en <= 1'b1;
          state <= ENG_CSUM_LO;
        end
        ENG_CSUM_LO: begin
          wr_en <= 1'b1;
          state <= ENG_SEND;
        end
        ENG_SEND:    state <= ENG_WAIT_TX;
        ENG_WAIT_TX: begin
          if (tx_done) begin
            state <= ENG_ACK;
          end
        end
        // hold ack until the receiver lets go of req
        ENG_ACK: begin
          frame_ack <= 1'b1;
          if (frame_ack && !i_frame_req) begin
            frame_ack <= 1'b0;
            state     <= ENG_IDLE;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    case (state)
      ENG_HDR_LD: hdr <= {hdr[47:0], i_rd_data};
      ENG_DECODE: csum <= '0;
      ENG_FILL: begin
        wr_addr <= idx;
        wr_data <= tmpl_byte(idx, cmd, hdr);
      end
      ENG_SUM_LD: csum <= csum + {8'h00, i_rd_data};
      ENG_CSUM_HI: begin
        wr_addr <= addr_t'(`CSUM_POS);
        wr_data <= csum[15:8];
      end
      ENG_CSUM_LO: begin
        wr_addr <= addr_t'(`CSUM_POS + 1);
        wr_data <= csum[7:0];
      end
      default: ;
    endcase
  end

  assign tx_start    = (state == ENG_SEND);
  // transmitter borrows the read port while sending
  assign o_rd_addr   = (state == ENG_WAIT_TX) ? tx_rd_addr : idx;
  assign o_wr        = '{en: wr_en, addr: wr_addr, data: wr_data};
  assign o_frame_ack = frame_ack;

  reply_tx u_reply_tx (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (tx_start),
    .o_done     (tx_done),
    .o_rd_addr  (tx_rd_addr),
    .i_rd_data  (i_rd_data),
    .o_tx       (o_tx),
    .i_tx_ready (i_tx_ready)
  );

endmodule

//--- logic/reply_tx.sv
`timescale 1ns/10ps
`include "mhp_defines.svh"

module reply_tx (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start,
  output logic              o_done,
  output mhp_pkg::addr_t    o_rd_addr,
  input  mhp_pkg::byte_t    i_rd_data,
  output mhp_pkg::tx_beat_t o_tx,
  input  logic              i_tx_ready
);
  import mhp_pkg::*;

  tx_state_e state;
  addr_t     idx;
  byte_t     data_q;
  logic      done;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= TX_IDLE;
      idx   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        TX_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= TX_FETCH;
          end
        end
        // address out this cycle, data in the next
        TX_FETCH: state <= TX_LOAD;
        TX_LOAD:  state <= TX_SEND;
        TX_SEND: begin
          if (i_tx_ready) begin
            if (idx == addr_t'(`REPLY_LEN - 1)) begin
              done  <= 1'b1;
              state <= TX_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= TX_FETCH;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // past the checksum the reply is padding
  always_ff @(posedge i_clk) begin
    if (state == TX_LOAD) begin
      data_q <= (idx <= addr_t'(`CSUM_POS + 1)) ? i_rd_data : 8'h00;
    end
  end

  assign o_rd_addr = idx;
  // beat goes out in the cycle ready is seen
  assign o_tx      = '{valid: (state == TX_SEND) && i_tx_ready, data: data_q};
  assign o_done    = done;

endmodule

//--- tb/mhp_assert.sv
`timescale 1ns/10ps

module mhp_assert (
  input logic i_clk,
  input logic i_rst,
  input logic i_req,
  input logic i_ack,
  input logic i_pop,
  input logic i_tx_valid,
  input logic i_tx_ready
);

  ////////////////////////////////////////////////////////////////////////////
  // frame handshake
  ////////////////////////////////////////////////////////////////////////////

  // req stays up until the engine answers
  a_req_held: assert property (
    @(posedge i_clk) disable iff (i_rst) (i_req && !i_ack) |=> i_req
  ) else $error("frame_req dropped before frame_ack");

  a_ack_needs_req: assert property (
    @(posedge i_clk) disable iff (i_rst) $rose(i_ack) |-> i_req
  ) else $error("frame_ack rose without frame_req");

  // held frame means the fifo fills
  a_no_pop_held: assert property (
    @(posedge i_clk) disable iff (i_rst) i_req |-> !i_pop
  ) else $error("byte popped while a frame is held");

  ////////////////////////////////////////////////////////////////////////////
  // output
  ////////////////////////////////////////////////////////////////////////////

  // a reply goes out only while its frame is still held
  a_valid_ready: assert property (
    @(posedge i_clk) disable iff (i_rst)
      i_tx_valid |-> (i_tx_ready && i_req && !i_ack)
  ) else $error("o_tx valid without i_tx_ready or outside a held frame");

endmodule

//--- tb/mhp_tb.sv
`timescale 1ns/10ps
`include "mhp_defines.svh"

module mhp_tb;
  import mhp_pkg::*;

  localparam int NUM_FRAMES   = 9;
  localparam int LONGEST      = 70;
  localparam int WATCH_CYCLES =
    NUM_FRAMES * (LONGEST * 4 + `RX_GAP_LIMIT + `REPLY_LEN * 8 + 100);

  logic     i_clk;
  logic     i_rst;
  byte_t    i_rx_data;
  logic     i_rx_ready;
  logic     o_rx_req;
  tx_beat_t o_tx;
  logic     i_tx_ready;

  // fifo contents and expected output
  byte_t   fifo_q [$];
  byte_t   cur_frame [$];
  byte_t   exp_q [$];
  string   name_q [$];

  bit      stall_en = 1'b0;
  bit      silent_win = 1'b0;
  int      stray_cnt = 0;
  int      out_pos = 0;
  byte_t   stray_b5 = 8'h00;
  byte_t   exp_b;

  mhp_top i_dut (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rx_data  (i_rx_data),
    .i_rx_ready (i_rx_ready),
    .o_rx_req   (o_rx_req),
    .o_tx       (o_tx),
    .i_tx_ready (i_tx_ready)
  );

  bind frame_rx mhp_assert u_rx_assert (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_req      (o_frame_req),
    .i_ack      (i_frame_ack),
    .i_pop      (o_rx_req),
    .i_tx_valid (1'b0),
    .i_tx_ready (1'b0)
  );

  bind reply_engine mhp_assert u_eng_assert (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_req      (i_frame_req),
    .i_ack      (o_frame_ack),
    .i_pop      (1'b0),
    .i_tx_valid (o_tx.valid),
    .i_tx_ready (i_tx_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // reply by the protocol rule, CMD_NONE when the frame stays silent
  function automatic cmd_op_e expected_reply(input byte_t frm [$],
                                             output byte_t rep [`REPLY_LEN]);
    byte_t       dtype;
    cmd_op_e     kind;
    logic [15:0] sum;
    foreach (rep[i]) rep[i] = 8'h00;
    if (frm.size() < `HDR_LEN) return CMD_NONE;
    dtype = frm[6];
    if (dtype[`ACK_BIT]) kind = CMD_NONE;
    else if (dtype[6:0] == `OP_PING) kind = CMD_PING;
    else if (dtype[6:0] == `OP_ADDR) kind = CMD_ADDR;
    else kind = CMD_NONE;
    if (kind == CMD_NONE) return CMD_NONE;
    // destination first, then source
    rep[0] = frm[2];
    rep[1] = frm[3];
    rep[2] = frm[0];
    rep[3] = frm[1];
    if (kind == CMD_PING) begin
      rep[5] = 8'h01;
      rep[6] = 8'h81;
    end else begin
      rep[5] = 8'h02;
      rep[6] = 8'h92;
      rep[7] = 8'h01;
      rep[8] = 8'h20;
    end
    sum = 16'h0000;
    for (int i = 0; i < `CSUM_POS; i++) sum = sum + 16'(rep[i]);
    rep[`CSUM_POS]     = sum[15:8];
    rep[`CSUM_POS + 1] = sum[7:0];
    return kind;
  endfunction

  // answer seen while a silent frame was out
  // any output at all counts as a reply
  function automatic cmd_op_e seen_kind(input int nbytes, input byte_t b5);
    if (nbytes == 0) return CMD_NONE;
    return (b5 == 8'h02) ? CMD_ADDR : CMD_PING;
  endfunction

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_byte(input string name, input int pos, input byte_t exp,
                            input byte_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s byte %0d: expected %02h, actual %02h",
               name, pos, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cmd(input string name, input cmd_op_e exp, input cmd_op_e act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock, fifo model, ready driver
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // byte shows up the cycle after the pop
  initial begin
    i_rx_data  = 8'h00;
    i_rx_ready = 1'b0;
    forever begin
      @(posedge i_clk);
      if (o_rx_req && fifo_q.size() == 0) begin
        $display("receiver popped an empty FIFO");
        abort_run();
      end else begin
        if (o_rx_req) i_rx_data <= fifo_q.pop_front();
        i_rx_ready <= (fifo_q.size() != 0);
      end
    end
  end

  initial begin
    void'($urandom(46));
    i_tx_ready = 1'b0;
    forever begin
      @(posedge i_clk);
      if (stall_en) i_tx_ready <= (($urandom % 3) != 0);
      else i_tx_ready <= 1'b1;
    end
  end

  // output collection
  always @(posedge i_clk) begin
    if (!i_rst && o_tx.valid) begin
      if (exp_q.size() != 0) begin
        exp_b = exp_q.pop_front();
        check_byte(name_q[0], out_pos, exp_b, o_tx.data);
        if (out_pos == `REPLY_LEN - 1) begin
          void'(name_q.pop_front());
          out_pos = 0;
        end else begin
          out_pos = out_pos + 1;
        end
      end else if (silent_win) begin
        // judged when the silent frame's window closes
        if (stray_cnt == 5) stray_b5 = o_tx.data;
        stray_cnt = stray_cnt + 1;
      end else begin
        $display("output byte %02h arrived with no reply pending", o_tx.data);
        abort_run();
      end
    end
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge i_clk);
    $display("timeout, the run did not finish within %0d cycles", WATCH_CYCLES);
    abort_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_frame(input logic [15:0] src, input logic [15:0] dst,
                             input byte_t dtype, input int len);
    frame_hdr_t hdr;
    hdr = '{src: src, dst: dst, size: 16'(len), dtype: dtype};
    cur_frame.delete();
    for (int i = 0; i < len; i++) begin
      if (i < `HDR_LEN) cur_frame.push_back(hdr[55 - 8 * i -: 8]);
      else cur_frame.push_back(byte_t'(i * 7 + 3));
    end
  endtask

  // queue the expected reply, feed the fifo, wait out the idle gap
  task automatic send_frame(input string name, output cmd_op_e kind);
    byte_t rep [`REPLY_LEN];
    kind = expected_reply(cur_frame, rep);
    if (kind != CMD_NONE) begin
      foreach (rep[i]) exp_q.push_back(rep[i]);
      name_q.push_back(name);
    end
    @(negedge i_clk);
    foreach (cur_frame[i]) fifo_q.push_back(cur_frame[i]);
    while (fifo_q.size() != 0) @(negedge i_clk);
    repeat (`RX_GAP_LIMIT + 16) @(negedge i_clk);
  endtask

  task automatic send_reply(input string name);
    cmd_op_e kind;
    send_frame(name, kind);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge i_clk);
    repeat (4) @(negedge i_clk);
  endtask

  // no output may follow a silent frame
  task automatic send_silent(input string name);
    cmd_op_e kind;
    wait_drain();
    stray_cnt  = 0;
    stray_b5   = 8'h00;
    silent_win = 1'b1;
    send_frame(name, kind);
    repeat (64) @(negedge i_clk);
    silent_win = 1'b0;
    check_cmd(name, kind, seen_kind(stray_cnt, stray_b5));
  endtask

  initial begin
    i_rst = 1'b1;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;

    build_frame(16'h1234, 16'h00ab, 8'h01, 10);
    send_reply("ping");
    // direction bit set, still a grant
    build_frame(16'h0f0e, 16'h0001, 8'h84, 7);
    send_reply("addr_grant");

    build_frame(16'h2222, 16'h3333, 8'h11, 9);
    send_silent("ack_flag");
    build_frame(16'h4444, 16'h5555, 8'h03, 8);
    send_silent("unknown_op");
    build_frame(16'h6666, 16'h7777, 8'h01, 5);
    send_silent("runt");

    stall_en = 1'b1;
    build_frame(16'h0102, 16'h0304, 8'h01, 12);
    send_reply("b2b_ping");
    build_frame(16'hfffe, 16'hfdfc, 8'h04, 16);
    send_reply("b2b_grant");
    build_frame(16'h8001, 16'h7ffe, 8'h81, 20);
    send_reply("stall_ping");
    build_frame(16'habcd, 16'h5a5a, 8'h04, LONGEST);
    send_reply("long_frame");
    wait_drain();

    repeat (10) @(negedge i_clk);
    if (exp_q.size() == 0 && name_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("replies still pending at the end of the run");
      abort_run();
    end
  end

endmodule

//--- verilog.f
+incdir+logic
logic/mhp_pkg.sv
logic/frame_rx.sv
logic/frame_ram.sv
logic/reply_tx.sv
logic/reply_engine.sv
logic/mhp_top.sv
tb/mhp_assert.sv
tb/mhp_tb.sv
